// File: filelist.f
shift_pkg.sv
shift_ctrl_if.sv
shift_fsm.sv
shift_counter.sv
shift_datapath.sv
shift_unit.sv
shift_unit_assert.sv
shift_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shift unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module shift_unit_tb --Mdir obj_dir -o shift_sim -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/shift_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Run failed"
   exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
   echo "Run ended without a pass (status $sim_status)"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "Simulator returned status $sim_status"
   exit 1
fi

exit 0

// File: shift_unit_tb.sv
`timescale 1ns/1ps

module shift_unit_tb;

   import shift_pkg::*;

   logic    clk;
   logic    reset;
   logic    ready;
   word_t   in;
   amount_t shift;
   logic    done;
   word_t   out;
   logic    last_bit;
   logic    sign_change16;
   logic    sign_change32;
   integer  seed;

   shift_unit shift_unit_i
   (
      .clk           (clk),
      .reset         (reset),
      .ready         (ready),
      .in            (in),
      .shift         (shift),
      .done          (done),
      .out           (out),
      .last_bit      (last_bit),
      .sign_change16 (sign_change16),
      .sign_change32 (sign_change32)
   );

   always #5 clk = ~clk; // 10 ns period.

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1, "stopped at %0t", $time);
   endtask

   // Poll the bound checker every cycle.
   always @(posedge clk)
   begin
      if (shift_unit_i.shift_unit_assert_i.error_count != 0)
      begin
         stop_with_failure("Assertion checker reported an error.");
      end
   end

   task automatic run_op(input word_t operand, input amount_t amount, input int hold);
      int waited;
      @(posedge clk);
      #1;
      in    = operand;
      shift = amount;
      ready = 1'b1;

      waited = 0;
      while (!done)
      begin
         if (waited == 40)
         begin
            stop_with_failure("Timed out waiting for done to rise.");
         end
         @(posedge clk);
         #1;
         waited++;
      end

      repeat (hold) @(posedge clk); // Back-pressure.
      #1;
      ready = 1'b0;

      waited = 0;
      while (done)
      begin
         if (waited == 40)
         begin
            stop_with_failure("Timed out waiting for done to fall.");
         end
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      word_t   r_operand;
      amount_t r_amount;
      int      r_hold;
      seed  = 32'h2e9a;
      clk   = 1'b0;
      reset = 1'b1;
      ready = 1'b0;
      in    = '0;
      shift = '0;

      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // Directed cases with known sign patterns.
      run_op(32'h8000_0001, 6'd0, 0);
      run_op(32'h4000_8000, 6'd1, 1);
      run_op(32'h0000_4001, 6'd31, 2);
      run_op(32'h8000_00f1, 6'h3f, 0);  // -1
      run_op(32'h8765_4321, 6'h20, 3);  // -32
      run_op(32'h7fff_ffff, 6'd5, 1);
      run_op(32'h0000_7fff, 6'd17, 0);

      for (int i = 0; i < 200; i++)
      begin
         r_operand = $random(seed);
         r_amount  = amount_t'($random(seed));
         r_hold    = int'($unsigned($random(seed)) % 4);
         run_op(r_operand, r_amount, r_hold);
      end

      repeat (2) @(posedge clk);
      #1;
      if (shift_unit_i.shift_unit_assert_i.error_count == 0)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
      begin
         stop_with_failure("Errors were counted at the end of the run.");
      end
   end

endmodule

// File: shift_unit_assert.sv
`timescale 1ns/1ps

module shift_unit_assert
(
   input logic                    clk,
   input logic                    reset,
   input logic                    ready,
   input shift_pkg::word_t        in,
   input shift_pkg::amount_t      shift,
   input logic                    done,
   input shift_pkg::word_t        out,
   input logic                    last_bit,
   input logic                    sign_change16,
   input logic                    sign_change32,
   input shift_pkg::shift_state_t state
);

   import shift_pkg::*;

   int      error_count = 0;
   word_t   m_operand;     // Operand taken with the request.
   amount_t m_amount;
   logic    m_sign;
   logic    pending;       // Request accepted and not yet released.
   int      since;         // Edges since the accepting edge.
   int      exp_latency;
   word_t   exp_out;
   logic    exp_last;
   logic    exp_sc16;
   logic    exp_sc32;

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (reset)
      begin
         pending <= 1'b0;
         since   <= 0;
      end
      else if (state == idle && ready)
      begin
         m_operand <= in;
         m_amount  <= shift;
         m_sign    <= in[word_width-1];
         pending   <= 1'b1;
         since     <= 1;
      end
      else if (pending)
      begin
         since <= since + 1;
         if (done && !ready)
         begin
            pending <= 1'b0; // Released by the requester.
         end
      end
   end

   always_comb
   begin
      int          n;
      logic [47:0] ext; // Low half with zeros below bit 0.
      n           = int'($signed(m_amount));
      ext         = {m_operand[15:0], 32'b0};
      exp_out     = m_operand;
      exp_last    = 1'b0;
      exp_sc16    = 1'b0;
      exp_sc32    = 1'b0;
      exp_latency = (n < 0) ? 1 - n : n + 1;
      if (n > 0)
      begin
         exp_out  = m_operand << n;
         exp_last = m_operand[32-n];
         for (int i = 1; i <= n; i++)
         begin
            if (m_operand[31-i] != m_operand[31])
            begin
               exp_sc32 = 1'b1;
            end
            if (ext[47-i] != ext[47])
            begin
               exp_sc16 = 1'b1;
            end
         end
      end
      else if (n < 0)
      begin
         exp_out  = m_operand >> (-n);
         exp_last = m_operand[-n-1];
         for (int i = 0; i < -n; i++)
         begin
            exp_out[word_width-1-i] = m_sign; // Sign captured with the request.
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   reset_clear: assert property (@(posedge clk)
      reset |=> (!done && out == '0 && !last_bit && !sign_change16 && !sign_change32))
      else begin $error("Mismatch at %0t: outputs not clear after reset", $time); error_count++; end

   latency: assert property (@(posedge clk) disable iff (reset)
      $rose(done) |-> (pending && since == exp_latency))
      else begin $error("Mismatch at %0t: done rose after %0d edges", $time, since); error_count++; end

   result: assert property (@(posedge clk) disable iff (reset)
      done |-> (out == exp_out && last_bit == exp_last))
      else begin $error("Mismatch at %0t: out %h last_bit %b", $time, out, last_bit); error_count++; end

   flags: assert property (@(posedge clk) disable iff (reset)
      done |-> (sign_change16 == exp_sc16 && sign_change32 == exp_sc32))
      else begin $error("Mismatch at %0t: sign change flags wrong", $time); error_count++; end

   hold: assert property (@(posedge clk) disable iff (reset)
      (done && ready) |=> done)
      else begin $error("Mismatch at %0t: done fell with ready high", $time); error_count++; end

   release_done: assert property (@(posedge clk) disable iff (reset)
      (done && !ready) |=> !done)
      else begin $error("Mismatch at %0t: done held after ready fell", $time); error_count++; end

   stable: assert property (@(posedge clk) disable iff (reset)
      (done && $past(done)) |-> ($stable(out) && $stable(sign_change16) && $stable(sign_change32)))
      else begin $error("Mismatch at %0t: result moved while done", $time); error_count++; end

endmodule

bind shift_unit shift_unit_assert shift_unit_assert_i
(
   .clk           (clk),
   .reset         (reset),
   .ready         (ready),
   .in            (in),
   .shift         (shift),
   .done          (done),
   .out           (out),
   .last_bit      (last_bit),
   .sign_change16 (sign_change16),
   .sign_change32 (sign_change32),
   .state         (shift_fsm_i.state)
);

// File: shift_unit.sv
`timescale 1ns/1ps

module shift_unit
(
   input  logic               clk,
   input  logic               reset,
   input  logic               ready,
   input  shift_pkg::word_t   in,
   input  shift_pkg::amount_t shift,
   output logic               done,
   output shift_pkg::word_t   out,
   output logic               last_bit,
   output logic               sign_change16,
   output logic               sign_change32
);

   logic amount_zero; // Zero shift, straight to last.

   ////////////////////////////////////////////////////////////
   // Step control shared by the three blocks
   ////////////////////////////////////////////////////////////

   shift_ctrl_if ctrl ();

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   shift_fsm shift_fsm_i
   (
      .clk         (clk),
      .reset       (reset),
      .ready       (ready),
      .amount_zero (amount_zero),
      .ctrl        (ctrl.fsm),
      .done        (done)
   );

   shift_counter shift_counter_i
   (
      .clk         (clk),
      .reset       (reset),
      .amount      (shift),
      .ctrl        (ctrl.counter),
      .amount_zero (amount_zero)
   );

   // Result and flags come straight from the datapath registers.
   shift_datapath shift_datapath_i
   (
      .clk           (clk),
      .reset         (reset),
      .operand       (in),
      .ctrl          (ctrl.datapath),
      .result        (out),
      .last_bit      (last_bit),
      .sign_change16 (sign_change16),
      .sign_change32 (sign_change32)
   );

endmodule

// File: shift_datapath.sv
`timescale 1ns/1ps

module shift_datapath
(
   input  logic             clk,
   input  logic             reset,
   input  shift_pkg::word_t operand,
   shift_ctrl_if.datapath   ctrl,
   output shift_pkg::word_t result,
   output logic             last_bit,
   output logic             sign_change16,
   output logic             sign_change32
);

   import shift_pkg::*;

   localparam int half_msb = word_width / 2 - 1; // Bit 15.

   logic  sign;          // Operand sign, fill for right shifts.
   logic  differ16;
   logic  differ32;
   word_t shifted_left;
   word_t shifted_right;

   ////////////////////////////////////////////////////////////
   // Next values
   ////////////////////////////////////////////////////////////

   // Sign change seen by the coming left step.
   assign differ16 = result[half_msb] ^ result[half_msb-1];
   assign differ32 = result[word_width-1] ^ result[word_width-2];

   assign shifted_left  = {result[word_width-2:0], 1'b0};
   assign shifted_right = {sign, result[word_width-1:1]};

   ////////////////////////////////////////////////////////////
   // Sign capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (ctrl.load)
      begin
         sign <= operand[word_width-1];
      end
   end

   ////////////////////////////////////////////////////////////
   // Result, last bit and sticky flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         result        <= '0;
         last_bit      <= 1'b0;
         sign_change16 <= 1'b0;
         sign_change32 <= 1'b0;
      end
      else if (ctrl.load)
      begin
         result        <= operand; // Zero shift leaves it here.
         last_bit      <= 1'b0;
         sign_change16 <= 1'b0;
         sign_change32 <= 1'b0;
      end
      else if (ctrl.step)
      begin
         if (ctrl.left)
         begin
            result   <= shifted_left;
            last_bit <= result[word_width-1];

            // Sticky until the next load.
            if (differ16)
            begin
               sign_change16 <= 1'b1;
            end
            if (differ32)
            begin
               sign_change32 <= 1'b1;
            end
         end
         else
         begin
            result   <= shifted_right; // Arithmetic, flags untouched.
            last_bit <= result[0];
         end
      end
   end

endmodule

// File: shift_counter.sv
`timescale 1ns/1ps

module shift_counter
(
   input  logic               clk,
   input  logic               reset,
   input  shift_pkg::amount_t amount,
   shift_ctrl_if.counter      ctrl,
   output logic               amount_zero
);

   import shift_pkg::*;

   amount_t count; // Remaining places, signed.

   ////////////////////////////////////////////////////////////
   // Count and direction
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count     <= '0;
         ctrl.left <= 1'b0;
      end
      else if (ctrl.load)
      begin
         count     <= amount;
         ctrl.left <= ~amount[amount_width-1]; // Sign clear means left.
      end
      else if (ctrl.step)
      begin
         // Walk toward zero from either side.
         if (ctrl.left)
         begin
            count <= count - amount_t'(1);
         end
         else
         begin
            count <= count + amount_t'(1);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // End detection
   ////////////////////////////////////////////////////////////

   // One place left to go: +1 on a left shift, -1 (all ones) on a right.
   always_comb
   begin
      if (ctrl.left)
      begin
         ctrl.final_step = (count == amount_t'(1));
      end
      else
      begin
         ctrl.final_step = (count == {amount_width{1'b1}});
      end
   end

   assign amount_zero = (amount == '0); // Taken from the live input.

endmodule

// File: shift_fsm.sv
`timescale 1ns/1ps

module shift_fsm
(
   input  logic         clk,
   input  logic         reset,
   input  logic         ready,
   input  logic         amount_zero,
   shift_ctrl_if.fsm    ctrl,
   output logic         done
);

   import shift_pkg::*;

   shift_state_t state;
   shift_state_t next_state;

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      next_state = state;
      case (state)
         idle:
         begin
            if (ready)
            begin
               // A zero shift has nothing to do.
               next_state = amount_zero ? last : running;
            end
         end
         running:
         begin
            if (ctrl.final_step)
            begin
               next_state = last;
            end
         end
         last:
         begin
            if (!ready)
            begin
               next_state = idle; // Requester let go.
            end
         end
         default:
         begin
            next_state = idle;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // State and done registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         done  <= 1'b0;
      end
      else
      begin
         state <= next_state;
         done  <= (next_state == last); // Mirrors the last state.
      end
   end

   // Strobes decode straight from the state.
   assign ctrl.load = (state == idle);
   assign ctrl.step = (state == running);

endmodule

// File: shift_ctrl_if.sv
`timescale 1ns/1ps

interface shift_ctrl_if;

   logic load;       // Idle cycle, registers take the inputs.
   logic step;       // Running cycle, one shift.
   logic left;       // Direction latched at load.
   logic final_step; // This step is the last one.

   // State machine issues the strobes and watches for the end.
   modport fsm
   (
      output load,
      output step,
      input  final_step
   );

   // Counter owns the direction and the end condition.
   modport counter
   (
      input  load,
      input  step,
      output left,
      output final_step
   );

   // Datapath only follows the strobes and direction.
   modport datapath
   (
      input load,
      input step,
      input left
   );

endinterface

// File: shift_pkg.sv
package shift_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   localparam int word_width   = 32; // Operand and result.
   localparam int amount_width = 6;  // Signed shift amount.

   ////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////

   // Operand and result word.
   typedef logic [word_width-1:0] word_t;

   // Shift amount, two's complement.
   // Positive shifts left, negative shifts right.
   typedef logic [amount_width-1:0] amount_t;

   ////////////////////////////////////////////////////////////
   // Control states
   ////////////////////////////////////////////////////////////

   // Idle tracks the inputs, running shifts one place per clock,
   // last holds the result until ready drops.
   typedef enum logic [1:0]
   {
      idle    = 2'b00,
      running = 2'b01,
      last    = 2'b10
   } shift_state_t;

endpackage
